//--- mpls_ingress.f
+incdir+verilog
verilog/ing_port_pkg.sv
verilog/ing_sched_pkg.sv
verilog/ing_axis_if.sv
verilog/ing_port_adapt.sv
verilog/ing_scheduler.sv
verilog/mpls_ingress.sv
testbench/mpls_ingress_asserts.sv
testbench/mpls_ingress_tb.sv

//--- Makefile
# Verilator build and run for the MPLS ingress testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f mpls_ingress.f \
		--top-module mpls_ingress_tb -o Vmpls_ingress_tb

run: compile
	@out="$$(./obj_dir/Vmpls_ingress_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

//--- testbench/mpls_ingress_tb.sv
/* Testbench for the MPLS ingress, random packets on both ports
   Model queues per port, checks packing, tagging, drops and arbitration */
`timescale 1ns/10ps
`default_nettype none

`include "mpls_ingress_consts.svh"

module mpls_ingress_tb;

  localparam int total_pkts = 300;

  logic clk = 1'b0;
  logic rst_n;
  logic [7:0] p8_tdata;
  logic p8_tvalid, p8_tlast;
  logic [15:0] p16_tdata;
  logic p16_tvalid, p16_tlast;
  logic out_tready;
  ing_port_pkg::bus_word_t out_tdata;
  ing_port_pkg::bus_keep_t out_tkeep;
  ing_port_pkg::port_idx_t out_tuser;
  logic out_tlast, out_tvalid;
  logic [`ING_NUM_PORTS-1:0] overflow;

  // Model state per port
  ing_port_pkg::bus_word_t exp_word [2][$];
  ing_port_pkg::bus_keep_t exp_keep [2][$];
  logic                    exp_last [2][$];
  ing_port_pkg::bus_word_t stg_word [2][$];
  ing_port_pkg::bus_keep_t stg_keep [2][$];
  logic                    stg_last [2][$];
  time                     pkt_time [2][$];
  ing_port_pkg::bus_word_t cur_word [2];
  ing_port_pkg::bus_keep_t cur_keep [2];
  int cur_cnt [2];
  int beats_left [2];
  int gap [2];
  logic pending [2];
  logic drop [2];

  // Run bookkeeping
  logic [31:0] lfsr = 32'ha50d685a;
  int started, dropped, recv_pkts, rdy_left, cycles;
  logic in_pkt, have_prev;
  ing_port_pkg::port_idx_t cur_port, prev_port;
  // Output times of the latest word and of the word before the last tlast
  time last_xfer, prev_ref;

  mpls_ingress mpls_ingress_inst (.*);

  bind mpls_ingress mpls_ingress_asserts mpls_ingress_asserts_inst (
    .clk(clk), .rst_n(rst_n), .out_tdata(out_tdata), .out_tkeep(out_tkeep),
    .out_tuser(out_tuser), .out_tlast(out_tlast), .out_tvalid(out_tvalid),
    .out_tready(out_tready), .overflow(overflow));

  always #50 clk = !clk;

  //////////////////////////////
  // Random bits and checks

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = lfsr[0];
      // Galois step, x^32 + x^22 + x^2 + x + 1
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input ing_port_pkg::bus_word_t got,
                            input ing_port_pkg::bus_word_t exp);
    if (got !== exp) fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_keep(input string name, input ing_port_pkg::bus_keep_t got,
                            input ing_port_pkg::bus_keep_t exp);
    if (got !== exp) fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_idx(input string name, input ing_port_pkg::port_idx_t got,
                           input ing_port_pkg::port_idx_t exp);
    if (got !== exp) fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("Mismatch %s got %h expected %h", name, got, exp));
  endtask

  //////////////////////////////
  // Stimulus

  task automatic drive_port(input int p, input logic v, input logic l, input logic [15:0] d);
    if (p == 0) begin
      p8_tvalid = v;
      p8_tlast  = l;
      p8_tdata  = d[7:0];
    end else begin
      p16_tvalid = v;
      p16_tlast  = l;
      p16_tdata  = d;
    end
  endtask

  // Commit the staged words, unless overflow hit this packet
  task automatic finish_packet(input int p);
    if (drop[p]) begin
      dropped++;
    end else begin
      for (int i = 0; i < stg_word[p].size(); i++) begin
        exp_word[p].push_back(stg_word[p][i]);
        exp_keep[p].push_back(stg_keep[p][i]);
        exp_last[p].push_back(stg_last[p][i]);
      end
      pkt_time[p].push_back($time);
    end
    stg_word[p].delete();
    stg_keep[p].delete();
    stg_last[p].delete();
  endtask

  task automatic step_port(input int p);
    int nb;
    logic [15:0] data;
    logic last;
    nb = (p == 0) ? 1 : 2;
    // Pulse belongs to the beat of the previous cycle
    if (overflow[p]) drop[p] = 1'b1;
    if (pending[p]) begin
      finish_packet(p);
      pending[p] = 1'b0;
    end
    if (beats_left[p] == 0 && gap[p] == 0 && started < total_pkts) begin
      beats_left[p] = (p == 0) ? 1 + int'(take_bits(6)) % 40 : 1 + int'(take_bits(5)) % 20;
      drop[p] = 1'b0;
      started++;
    end
    if (beats_left[p] > 0) begin
      data = 16'(take_bits(8 * nb));
      last = (beats_left[p] == 1);
      for (int b = 0; b < nb; b++) begin
        cur_word[p][cur_cnt[p]*8 +: 8] = data[b*8 +: 8];
        // One keep bit for each byte placed
        cur_keep[p][cur_cnt[p]] = 1'b1;
        cur_cnt[p]++;
      end
      // LSB-first packing, tlast flushes a partial word
      if (cur_cnt[p] == `ING_BUS_BYTES || last) begin
        stg_word[p].push_back(cur_word[p]);
        stg_keep[p].push_back(cur_keep[p]);
        stg_last[p].push_back(last);
        cur_word[p] = '0;
        cur_keep[p] = '0;
        cur_cnt[p] = 0;
      end
      drive_port(p, 1'b1, last, data);
      beats_left[p]--;
      if (beats_left[p] == 0) begin
        pending[p] = 1'b1;
        gap[p] = 2 + int'(take_bits(3));
      end
    end else begin
      drive_port(p, 1'b0, 1'b0, 16'h0000);
      if (gap[p] > 0) gap[p]--;
    end
  endtask

  // Long ready and stall stretches
  task automatic step_ready();
    if (rdy_left == 0) begin
      out_tready = take_bits(1);
      rdy_left = 1 + int'(take_bits(6));
    end
    rdy_left--;
  endtask

  //////////////////////////////
  // Output monitor

  always @(negedge clk) begin
    if (rst_n && out_tvalid && out_tready) begin
      if (!in_pkt) begin
        cur_port = out_tuser;
        if (exp_word[cur_port].size() == 0)
          fail_now("Packet arrived on a port with no packet expected");
        // Same port twice while the other port's packet was visible at the grant
        if (have_prev && cur_port == prev_port && pkt_time[int'(cur_port) ^ 1].size() > 0 &&
            pkt_time[int'(cur_port) ^ 1][0] + 100 < prev_ref)
          fail_now("Round-robin skipped a waiting port");
        in_pkt = 1'b1;
      end
      check_idx("out_tuser", out_tuser, cur_port);
      if (exp_word[cur_port].size() == 0) fail_now("Packet longer than expected");
      check_word("out_tdata", out_tdata, exp_word[cur_port].pop_front());
      check_keep("out_tkeep", out_tkeep, exp_keep[cur_port].pop_front());
      check_flag("out_tlast", out_tlast, exp_last[cur_port].pop_front());
      if (out_tlast) begin
        in_pkt = 1'b0;
        have_prev = 1'b1;
        prev_port = cur_port;
        // Tlast word entered the output stage after the word before it left
        prev_ref = last_xfer;
        void'(pkt_time[cur_port].pop_front());
        recv_pkts++;
      end
      last_xfer = $time;
    end
  end

  //////////////////////////////
  // Sequence

  initial begin
    rst_n = 1'b0;
    drive_port(0, 1'b0, 1'b0, 16'h0000);
    drive_port(1, 1'b0, 1'b0, 16'h0000);
    out_tready = 1'b0;
    in_pkt = 1'b0;
    have_prev = 1'b0;
    last_xfer = 0;
    prev_ref = 0;
    started = 0;
    dropped = 0;
    recv_pkts = 0;
    rdy_left = 0;
    for (int p = 0; p < 2; p++) begin
      cur_word[p] = '0;
      cur_keep[p] = '0;
      cur_cnt[p] = 0;
      beats_left[p] = 0;
      gap[p] = 2;
      pending[p] = 1'b0;
      drop[p] = 1'b0;
    end
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_flag("out_tvalid", out_tvalid, 1'b0);
    check_flag("overflow[0]", overflow[0], 1'b0);
    check_flag("overflow[1]", overflow[1], 1'b0);
    cycles = 0;
    while (started < total_pkts || beats_left[0] > 0 || beats_left[1] > 0 ||
           pending[0] || pending[1]) begin
      @(posedge clk);
      #1;
      step_ready();
      step_port(0);
      step_port(1);
      cycles++;
      if (cycles > 200000) fail_now("Timeout while sending packets");
    end
    // Drain with the consumer always ready
    cycles = 0;
    while (exp_word[0].size() > 0 || exp_word[1].size() > 0 || in_pkt) begin
      @(posedge clk);
      #1;
      out_tready = 1'b1;
      step_port(0);
      step_port(1);
      cycles++;
      if (cycles > 5000) fail_now("Timeout while draining expected packets");
    end
    if (recv_pkts + dropped == total_pkts) begin
      $display("Testbench passed");
      $finish;
    end else begin
      fail_now($sformatf("Packet count wrong, %0d received and %0d dropped",
                         recv_pkts, dropped));
    end
  end

endmodule

`default_nettype wire

//--- testbench/mpls_ingress_asserts.sv
/* Converged-bus checks for the MPLS ingress
   Output hold under back-pressure, tuser per packet, reset and overflow pulses */
`timescale 1ns/10ps
`default_nettype none

`include "mpls_ingress_consts.svh"

module mpls_ingress_asserts (
  input wire logic                      clk,
  input wire logic                      rst_n,
  input wire ing_port_pkg::bus_word_t   out_tdata,
  input wire ing_port_pkg::bus_keep_t   out_tkeep,
  input wire ing_port_pkg::port_idx_t   out_tuser,
  input wire logic                      out_tlast,
  input wire logic                      out_tvalid,
  input wire logic                      out_tready,
  input wire logic [`ING_NUM_PORTS-1:0] overflow
);

  // Inside a packet, and the port it belongs to
  logic                    mid_pkt;
  ing_port_pkg::port_idx_t pkt_user;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mid_pkt  <= 1'b0;
      pkt_user <= '0;
    end else if (out_tvalid && out_tready) begin
      mid_pkt  <= !out_tlast;
      pkt_user <= out_tuser;
    end
  end

  //////////////////////////////
  // Output bus properties

  // Stalled word holds still
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) &&
      $stable(out_tkeep) && $stable(out_tuser) && $stable(out_tlast))
    else $error("Output word changed while stalled");

  // No port switch until tlast
  a_tuser: assert property (@(posedge clk) disable iff (!rst_n)
    out_tvalid && mid_pkt |-> out_tuser == pkt_user)
    else $error("out_tuser changed inside a packet");

  // Quiet outputs right after reset
  a_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !out_tvalid && overflow == '0)
    else $error("Outputs active after reset");

  // Overflow is a single-cycle pulse
  a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    |overflow |=> (overflow & $past(overflow)) == '0)
    else $error("Overflow held for more than one cycle");

endmodule

`default_nettype wire

//--- verilog/mpls_ingress.sv
/* MPLS router ingress, merges an 8-bit and a 16-bit port onto one 32-bit bus */
`timescale 1ns/10ps
`default_nettype none

`include "mpls_ingress_consts.svh"

module mpls_ingress (
  input  wire logic                      clk,
  input  wire logic                      rst_n,

  // 8-bit physical port
  input  wire logic [7:0]                p8_tdata,
  input  wire logic                      p8_tvalid,
  input  wire logic                      p8_tlast,

  // 16-bit physical port
  input  wire logic [15:0]               p16_tdata,
  input  wire logic                      p16_tvalid,
  input  wire logic                      p16_tlast,

  // Converged bus
  output wire ing_port_pkg::bus_word_t   out_tdata,
  output wire ing_port_pkg::bus_keep_t   out_tkeep,
  output wire ing_port_pkg::port_idx_t   out_tuser,
  output wire logic                      out_tlast,
  output wire logic                      out_tvalid,
  input  wire logic                      out_tready,

  // Buffer overflow pulses, bit 0 for the 8-bit port
  output wire logic [`ING_NUM_PORTS-1:0] overflow
);

  // Adapter to scheduler streams
  ing_axis_if port_bus [`ING_NUM_PORTS] ();

  //////////////////////////////
  // Port adapters

  // Port 0, four beats per word
  ing_port_adapt #(
    .in_bytes  (1)
  ) port8_adapt_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_tdata  (p8_tdata),
    .in_tvalid (p8_tvalid),
    .in_tlast  (p8_tlast),
    .overflow  (overflow[0]),
    .out       (port_bus[0])
  );

  // Port 1, two beats per word
  ing_port_adapt #(
    .in_bytes  (2)
  ) port16_adapt_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_tdata  (p16_tdata),
    .in_tvalid (p16_tvalid),
    .in_tlast  (p16_tlast),
    .overflow  (overflow[1]),
    .out       (port_bus[1])
  );

  //////////////////////////////
  // Scheduler

  ing_scheduler ing_scheduler_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .ports      (port_bus),
    .out_tdata  (out_tdata),
    .out_tkeep  (out_tkeep),
    .out_tuser  (out_tuser),
    .out_tlast  (out_tlast),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready)
  );

endmodule

`default_nettype wire

//--- verilog/ing_scheduler.sv
/* Packet round-robin scheduler onto the converged bus
   One registered output stage, port index tagged on tuser */
`timescale 1ns/10ps
`default_nettype none

`include "mpls_ingress_consts.svh"

module ing_scheduler (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  ing_axis_if.sink                   ports [`ING_NUM_PORTS],
  output ing_port_pkg::bus_word_t    out_tdata,
  output ing_port_pkg::bus_keep_t    out_tkeep,
  output ing_port_pkg::port_idx_t    out_tuser,
  output logic                       out_tlast,
  output logic                       out_tvalid,
  input  wire logic                  out_tready
);

  // Port-side copies of the interface array
  ing_port_pkg::bus_word_t   in_data [`ING_NUM_PORTS];
  ing_port_pkg::bus_keep_t   in_keep [`ING_NUM_PORTS];
  logic [`ING_NUM_PORTS-1:0] in_valid;
  logic [`ING_NUM_PORTS-1:0] in_last;

  // Arbiter state
  ing_sched_pkg::sched_state_t state;
  ing_sched_pkg::grant_t       grant;
  ing_sched_pkg::grant_t       next_grant;
  ing_port_pkg::port_idx_t     last_port;
  ing_port_pkg::port_idx_t     next_idx;

  // Transfer control
  logic load_ok;
  logic sel_valid;
  logic xfer;

  // Output register free, or emptying this cycle
  assign load_ok = !out_tvalid || out_tready;

  for (genvar i = 0; i < `ING_NUM_PORTS; i++) begin : g_port
    assign in_data[i]  = ports[i].tdata;
    assign in_keep[i]  = ports[i].tkeep;
    assign in_valid[i] = ports[i].tvalid;
    assign in_last[i]  = ports[i].tlast;
    // Ready goes only to the granted port
    assign ports[i].tready = grant[i] && load_ok;
  end

  // Granted port has a word and the register can take it
  assign sel_valid = |(in_valid & grant);
  assign xfer      = sel_valid && load_ok;

  //////////////////////////////
  // Round-robin pick

  always_comb begin
    int cand;
    next_grant = '0;
    next_idx   = last_port;
    // Walk back from the farthest port so the nearest one after last_port wins
    for (int k = `ING_NUM_PORTS; k >= 1; k--) begin
      cand = (int'(last_port) + k) % `ING_NUM_PORTS;
      if (in_valid[cand]) begin
        next_grant = ing_sched_pkg::grant_t'(1) << cand;
        next_idx   = ing_port_pkg::port_idx_t'(cand);
      end
    end
  end

  //////////////////////////////
  // FSM and output valid

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ing_sched_pkg::SCHED_IDLE;
      grant      <= '0;
      last_port  <= '0;
      out_tvalid <= 1'b0;
    end else begin
      case (state)
        ing_sched_pkg::SCHED_IDLE: begin
          // Sample pending packets and lock onto one
          if (|in_valid) begin
            state     <= ing_sched_pkg::SCHED_PACKET;
            grant     <= next_grant;
            last_port <= next_idx;
          end
        end
        ing_sched_pkg::SCHED_PACKET: begin
          // Release once the tlast word is taken
          if (xfer && in_last[last_port]) begin
            state <= ing_sched_pkg::SCHED_IDLE;
            grant <= '0;
          end
        end
      endcase
      if (xfer) begin
        out_tvalid <= 1'b1;
      end else if (out_tready) begin
        out_tvalid <= 1'b0;
      end
    end
  end

  // Payload holds while the consumer stalls
  always_ff @(posedge clk) begin
    if (xfer) begin
      out_tdata <= in_data[last_port];
      out_tkeep <= in_keep[last_port];
      out_tlast <= in_last[last_port];
      // last_port is the granted port here
      out_tuser <= last_port;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ing_port_adapt.sv
/* Port adapter, packs narrow beats into bus words and buffers whole packets
   Drops the tail of a packet that does not fit and flags overflow */
`timescale 1ns/10ps
`default_nettype none

`include "mpls_ingress_consts.svh"

module ing_port_adapt #(
  parameter int in_bytes = 1
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic [in_bytes*8-1:0] in_tdata,
  input  wire logic                  in_tvalid,
  input  wire logic                  in_tlast,
  output logic                       overflow,
  ing_axis_if.source                 out
);

  localparam int bus_bytes = `ING_BUS_BYTES;
  localparam int depth     = `ING_FIFO_WORDS;
  localparam int addr_w    = $clog2(depth);
  localparam int cnt_w     = $clog2(bus_bytes + 1);

  // Assembly state
  ing_port_pkg::bus_word_t asm_data;
  ing_port_pkg::bus_word_t word_next;
  ing_port_pkg::bus_word_t wr_data;
  ing_port_pkg::bus_keep_t wr_keep;
  logic [cnt_w-1:0]        asm_cnt;
  logic [cnt_w-1:0]        next_cnt;

  // Write control
  logic beat;
  logic wr_en;
  logic wr_ok;
  logic wr_fail;
  logic full;
  logic dropping;

  // Tentative, committed, visible and read pointers
  ing_port_pkg::fifo_ptr_t wr_ptr;
  ing_port_pkg::fifo_ptr_t commit_ptr;
  ing_port_pkg::fifo_ptr_t commit_vis;
  ing_port_pkg::fifo_ptr_t rd_ptr;

  // Packet buffer
  ing_port_pkg::bus_word_t mem_data [depth];
  ing_port_pkg::bus_keep_t mem_keep [depth];
  logic                    mem_last [depth];

  //////////////////////////////
  // Word assembly

  always_comb begin
    // Drop the new beat in at the current byte offset, LSB first
    word_next = asm_data;
    word_next[asm_cnt*8 +: in_bytes*8] = in_tdata;
    next_cnt = asm_cnt + cnt_w'(in_bytes);
    // Bytes held once this beat lands
    wr_keep = ing_port_pkg::bus_keep_t'((1 << next_cnt) - 1);
    // Unused bytes of a flushed word read as zero
    for (int b = 0; b < bus_bytes; b++) begin
      wr_data[b*8 +: 8] = wr_keep[b] ? word_next[b*8 +: 8] : 8'h00;
    end
  end

  // Beats of a dropped packet are ignored
  assign beat = in_tvalid && !dropping;
  // Word complete, or tlast flushes a partial one
  assign wr_en = beat && ((next_cnt == cnt_w'(bus_bytes)) || in_tlast);

  // Full when pointers differ only in the wrap bit
  assign full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
  assign wr_ok   = wr_en && !full;
  assign wr_fail = wr_en && full;

  // Partial word being assembled
  always_ff @(posedge clk) begin
    if (beat && !wr_en) begin
      asm_data <= word_next;
    end
  end

  //////////////////////////////
  // Commit and drop control

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      asm_cnt    <= '0;
      wr_ptr     <= '0;
      commit_ptr <= '0;
      commit_vis <= '0;
      dropping   <= 1'b0;
      overflow   <= 1'b0;
    end else begin
      // One-cycle pulse after the failed write
      overflow   <= wr_fail;
      // Committed packets show up one cycle late
      commit_vis <= commit_ptr;
      if (beat) begin
        asm_cnt <= wr_en ? '0 : next_cnt;
      end
      if (wr_fail) begin
        // Throw away what this packet already wrote
        wr_ptr <= commit_ptr;
      end else if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (wr_ok && in_tlast) begin
        commit_ptr <= wr_ptr + 1'b1;
      end
      // Skip the rest of the packet, unless that was its last beat
      if (wr_fail && !in_tlast) begin
        dropping <= 1'b1;
      end else if (dropping && in_tvalid && in_tlast) begin
        dropping <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem_data[wr_ptr[addr_w-1:0]] <= wr_data;
      mem_keep[wr_ptr[addr_w-1:0]] <= wr_keep;
      mem_last[wr_ptr[addr_w-1:0]] <= in_tlast;
    end
  end

  //////////////////////////////
  // Read side

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (out.tvalid && out.tready) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Only committed words are offered
  assign out.tvalid = (rd_ptr != commit_vis);
  assign out.tdata  = mem_data[rd_ptr[addr_w-1:0]];
  assign out.tkeep  = mem_keep[rd_ptr[addr_w-1:0]];
  assign out.tlast  = mem_last[rd_ptr[addr_w-1:0]];

endmodule

`default_nettype wire

//--- verilog/ing_axis_if.sv
/* Converged-bus stream between a port adapter and the scheduler
   Valid/ready handshake, word moves when both are high */
`timescale 1ns/10ps
`default_nettype none

interface ing_axis_if;

  // Word payload
  ing_port_pkg::bus_word_t tdata;
  ing_port_pkg::bus_keep_t tkeep;
  // Last word of a packet
  logic tlast;

  // Handshake
  logic tvalid;
  logic tready;

  // Adapter side
  modport source (output tdata, tkeep, tlast, tvalid, input tready);

  // Scheduler side
  modport sink (input tdata, tkeep, tlast, tvalid, output tready);

endinterface

`default_nettype wire

//--- verilog/ing_sched_pkg.sv
/* Ingress scheduler types */
`default_nettype none

`include "mpls_ingress_consts.svh"

package ing_sched_pkg;

  // Idle between packets, or locked onto one port
  typedef enum logic {SCHED_IDLE, SCHED_PACKET} sched_state_t;

  // One-hot port grant
  typedef logic [`ING_NUM_PORTS-1:0] grant_t;

endpackage

`default_nettype wire

//--- verilog/ing_port_pkg.sv
/* Ingress data-path types
   Bus words, byte enables, port index and buffer pointers */
`default_nettype none

`include "mpls_ingress_consts.svh"

package ing_port_pkg;

  // Converged-bus data word
  typedef logic [`ING_BUS_BYTES*8-1:0] bus_word_t;

  // One valid bit per byte of a bus word
  typedef logic [`ING_BUS_BYTES-1:0] bus_keep_t;

  // Physical port number, carried on tuser
  typedef logic [$clog2(`ING_NUM_PORTS)-1:0] port_idx_t;

  // Buffer address plus one wrap bit
  typedef logic [$clog2(`ING_FIFO_WORDS):0] fifo_ptr_t;

endpackage

`default_nettype wire

//--- verilog/mpls_ingress_consts.svh
/* MPLS ingress constants
   Converged-bus width, port buffer depth and port count */
`ifndef MPLS_INGRESS_CONSTS_SVH
`define MPLS_INGRESS_CONSTS_SVH

// Bytes per converged-bus word
`define ING_BUS_BYTES 4

// Words held by each port buffer
// must be a power of two
`define ING_FIFO_WORDS 16

// Physical ports merged onto the converged bus
`define ING_NUM_PORTS 2

`endif
